//--- logic/cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

   // Datapath widths
   localparam int WORD_W = 32;
   localparam int REG_W  = 5;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [REG_W-1:0]  regbits_t;

   // Decoded opcodes as issued by the front end
   typedef enum logic [3:0] {
      OP_ADD  = 4'h0,
      OP_SUB  = 4'h1,
      OP_AND  = 4'h2,
      OP_OR   = 4'h3,
      OP_XOR  = 4'h4,
      OP_SLT  = 4'h5,   // Signed compare
      OP_SLL  = 4'h6,
      OP_LUI  = 4'h7,
      OP_LW   = 4'h8,
      OP_SW   = 4'h9,
      OP_BEQ  = 4'ha,
      OP_BNE  = 4'hb,
      OP_JAL  = 4'hc,
      OP_HALT = 4'hd
   } alu_op_t;

   // Write-back source
   typedef enum logic [1:0] {
      WB_ALU = 2'd0,
      WB_MEM = 2'd1,
      WB_NPC = 2'd2
   } wb_sel_t;

   // Data memory geometry and latency
   localparam int DMEM_DEPTH = 64;
   localparam int DMEM_AW    = 6;
   localparam int DMEM_WAIT  = 2;

   // Wait counter wide enough to reach DMEM_WAIT
   localparam int DMEM_CW    = $clog2(DMEM_WAIT + 1);

endpackage

`default_nettype wire

//--- logic/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
   input  cpu_types_pkg::alu_op_t op,
   input  cpu_types_pkg::word_t   rdat1,
   input  cpu_types_pkg::word_t   rdat2,
   input  cpu_types_pkg::word_t   imm,
   input  cpu_types_pkg::word_t   npc,
   input  logic                   regwrite_req,
   output cpu_types_pkg::word_t   alu_result,
   output logic                   zero_flag,
   output logic                   branch_taken,
   output cpu_types_pkg::word_t   branch_target,
   output logic                   mem_read,
   output logic                   mem_write,
   output cpu_types_pkg::wb_sel_t wb_sel,
   output logic                   regwrite,
   output logic                   halt
);
   import cpu_types_pkg::*;

   word_t diff;
   word_t offset;
   logic  writes_reg;

   assign diff      = rdat1 - rdat2;
   assign offset    = imm << 2;    // Word offset to byte offset
   assign zero_flag = (diff == '0);

   // Decode and ALU
   always_comb begin
      alu_result = diff;
      writes_reg = 1'b1;
      mem_read   = 1'b0;
      mem_write  = 1'b0;
      wb_sel     = WB_ALU;
      halt       = 1'b0;
      case (op)
         OP_ADD:  alu_result = rdat1 + rdat2;
         OP_SUB:  alu_result = diff;
         OP_AND:  alu_result = rdat1 & rdat2;
         OP_OR:   alu_result = rdat1 | rdat2;
         OP_XOR:  alu_result = rdat1 ^ rdat2;
         OP_SLT:  alu_result = {31'b0, $signed(rdat1) < $signed(rdat2)};
         OP_SLL:  alu_result = rdat1 << rdat2[4:0];
         OP_LUI:  alu_result = {imm[15:0], 16'h0000};
         OP_LW: begin
            alu_result = rdat1 + imm;   // Effective address
            mem_read   = 1'b1;
            wb_sel     = WB_MEM;
         end
         OP_SW: begin
            alu_result = rdat1 + imm;
            mem_write  = 1'b1;
            writes_reg = 1'b0;
         end
         OP_BEQ, OP_BNE: writes_reg = 1'b0;
         OP_JAL:  wb_sel = WB_NPC;      // Link value
         OP_HALT: begin
            writes_reg = 1'b0;
            halt       = 1'b1;
         end
         default: writes_reg = 1'b0;
      endcase
   end

   // Branch resolution
   always_comb begin
      case (op)
         OP_BEQ:  branch_taken = zero_flag;
         OP_BNE:  branch_taken = ~zero_flag;
         OP_JAL:  branch_taken = 1'b1;
         default: branch_taken = 1'b0;
      endcase
   end

   assign branch_target = (op == OP_JAL) ? offset : npc + offset;   // JAL is absolute
   assign regwrite      = regwrite_req & writes_reg;

endmodule

`default_nettype wire

//--- logic/ex_mem_latch.sv
`timescale 1ns/10ps
`default_nettype none

module ex_mem_latch (
   input  logic                    CLK,
   input  logic                    nRST,
   input  logic                    flush,
   input  logic                    wen,
   input  logic                    mem_read,
   input  logic                    mem_write,
   input  logic                    regwrite,
   input  cpu_types_pkg::wb_sel_t  wb_sel,
   input  logic                    halt,
   input  logic                    branch_taken,
   input  cpu_types_pkg::word_t    alu_result,
   input  cpu_types_pkg::word_t    store_data,
   input  cpu_types_pkg::word_t    npc,
   input  cpu_types_pkg::word_t    branch_target,
   input  cpu_types_pkg::regbits_t dest,
   output logic                    mem_read_q,
   output logic                    mem_write_q,
   output logic                    regwrite_q,
   output cpu_types_pkg::wb_sel_t  wb_sel_q,
   output logic                    halt_q,
   output logic                    branch_taken_q,
   output cpu_types_pkg::word_t    alu_result_q,
   output cpu_types_pkg::word_t    store_data_q,
   output cpu_types_pkg::word_t    npc_q,
   output cpu_types_pkg::word_t    branch_target_q,
   output cpu_types_pkg::regbits_t dest_q
);
   import cpu_types_pkg::*;

   always_ff @(posedge CLK, negedge nRST) begin
      if (~nRST) begin
         mem_read_q      <= 1'b0;
         mem_write_q     <= 1'b0;
         regwrite_q      <= 1'b0;
         wb_sel_q        <= WB_ALU;
         halt_q          <= 1'b0;
         branch_taken_q  <= 1'b0;
         alu_result_q    <= '0;
         store_data_q    <= '0;
         npc_q           <= '0;
         branch_target_q <= '0;
         dest_q          <= '0;
      end else if (wen) begin
         if (flush) begin
            // Bubble
            mem_read_q      <= 1'b0;
            mem_write_q     <= 1'b0;
            regwrite_q      <= 1'b0;
            wb_sel_q        <= WB_ALU;
            halt_q          <= 1'b0;
            branch_taken_q  <= 1'b0;
            alu_result_q    <= '0;
            store_data_q    <= '0;
            npc_q           <= '0;
            branch_target_q <= '0;
            dest_q          <= '0;
         end else begin
            mem_read_q      <= mem_read;
            mem_write_q     <= mem_write;
            regwrite_q      <= regwrite;
            wb_sel_q        <= wb_sel;
            halt_q          <= halt;
            branch_taken_q  <= branch_taken;
            alu_result_q    <= alu_result;
            store_data_q    <= store_data;
            npc_q           <= npc;
            branch_target_q <= branch_target;
            dest_q          <= dest;
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/data_memory.sv
`timescale 1ns/10ps
`default_nettype none

module data_memory (
   input  logic                 CLK,
   input  logic                 nRST,
   input  logic                 mem_read,
   input  logic                 mem_write,
   input  cpu_types_pkg::word_t addr,
   input  cpu_types_pkg::word_t wdata,
   output cpu_types_pkg::word_t rdata,
   output logic                 dhit
);
   import cpu_types_pkg::*;

   word_t dmem [DMEM_DEPTH];

   logic [DMEM_AW-1:0] widx;
   logic [DMEM_CW-1:0] wait_cnt;
   logic               access;

   assign widx   = addr[DMEM_AW+1:2];   // Word address
   assign access = mem_read | mem_write;
   assign dhit   = access && (wait_cnt == DMEM_CW'(DMEM_WAIT));

   // Latency counter restarts after each hit
   always_ff @(posedge CLK, negedge nRST) begin
      if (~nRST) begin
         wait_cnt <= '0;
      end else if (~access || dhit) begin
         wait_cnt <= '0;
      end else begin
         wait_cnt <= wait_cnt + 1'b1;
      end
   end

   always_ff @(posedge CLK) begin
      if (mem_write && dhit) begin
         dmem[widx] <= wdata;   // Commits on the hit edge
      end
   end

   assign rdata = dmem[widx];

endmodule

`default_nettype wire

//--- logic/mem_wb_latch.sv
`timescale 1ns/10ps
`default_nettype none

module mem_wb_latch (
   input  logic                    CLK,
   input  logic                    nRST,
   input  logic                    mem_op,
   input  logic                    dhit,
   input  logic                    regwrite,
   input  cpu_types_pkg::wb_sel_t  wb_sel,
   input  cpu_types_pkg::word_t    alu_result,
   input  cpu_types_pkg::word_t    rdata,
   input  cpu_types_pkg::word_t    npc,
   input  cpu_types_pkg::regbits_t dest,
   output logic                    wb_valid,
   output cpu_types_pkg::regbits_t wb_dest,
   output cpu_types_pkg::word_t    wb_data
);
   import cpu_types_pkg::*;

   word_t wb_value;
   logic  capture;

   always_comb begin
      case (wb_sel)
         WB_MEM:  wb_value = rdata;
         WB_NPC:  wb_value = npc;
         default: wb_value = alu_result;
      endcase
   end

   assign capture = ~mem_op | dhit;   // Memory ops wait for their hit

   always_ff @(posedge CLK, negedge nRST) begin
      if (~nRST) begin
         wb_valid <= 1'b0;
         wb_dest  <= '0;
         wb_data  <= '0;
      end else if (capture) begin
         wb_valid <= regwrite;
         wb_dest  <= dest;
         wb_data  <= wb_value;
      end else begin
         wb_valid <= 1'b0;
         wb_dest  <= '0;
         wb_data  <= '0;
      end
   end

endmodule

`default_nettype wire

//--- logic/hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
   input  logic CLK,
   input  logic nRST,
   input  logic mem_op,
   input  logic dhit,
   input  logic branch_taken,
   input  logic halt,
   output logic ex_mem_wen,
   output logic flush,
   output logic halted
);

   logic mem_stall;

   assign mem_stall = mem_op & ~dhit;   // Access still outstanding

   // HALT in EX/MEM freezes the latch for good
   assign ex_mem_wen = nRST & ~mem_stall & ~halt & ~halted;

   // Squash the slot behind a taken branch
   assign flush = branch_taken;

   always_ff @(posedge CLK, negedge nRST) begin
      if (~nRST) begin
         halted <= 1'b0;
      end else if (halt) begin
         halted <= 1'b1;   // Sticky until reset
      end
   end

endmodule

`default_nettype wire

//--- logic/mips_backend.sv
`timescale 1ns/10ps
`default_nettype none

module mips_backend (
   input  logic                    CLK,
   input  logic                    nRST,
   input  logic                    issue_valid,
   input  cpu_types_pkg::alu_op_t  op,
   input  cpu_types_pkg::word_t    rdat1,
   input  cpu_types_pkg::word_t    rdat2,
   input  cpu_types_pkg::word_t    imm,
   input  cpu_types_pkg::word_t    npc,
   input  cpu_types_pkg::regbits_t dest,
   input  logic                    regwrite_req,
   output logic                    issue_ready,
   output logic                    wb_valid,
   output cpu_types_pkg::regbits_t wb_dest,
   output cpu_types_pkg::word_t    wb_data,
   output logic                    branch_taken,
   output cpu_types_pkg::word_t    branch_target,
   output logic                    halted
);
   import cpu_types_pkg::*;

   // Execute outputs
   word_t    ex_alu_result;
   word_t    ex_branch_target;
   wb_sel_t  ex_wb_sel;
   logic     ex_branch_taken;
   logic     ex_mem_read;
   logic     ex_mem_write;
   logic     ex_regwrite;
   logic     ex_halt;

   // EX/MEM contents
   word_t    mem_alu_result;
   word_t    mem_store_data;
   word_t    mem_npc;
   regbits_t mem_dest;
   wb_sel_t  mem_wb_sel;
   logic     mem_rd;
   logic     mem_wr;
   logic     mem_regwrite;
   logic     mem_halt;
   logic     mem_op;

   word_t    dmem_rdata;
   logic     dhit;
   logic     ex_mem_wen;
   logic     flush;
   logic     latch_flush;

   assign mem_op      = mem_rd | mem_wr;
   assign issue_ready = ex_mem_wen;
   assign latch_flush = flush | ~issue_valid;   // Idle cycle loads a bubble

   execute_stage i_execute_stage (
      .op(op), .rdat1(rdat1), .rdat2(rdat2), .imm(imm), .npc(npc),
      .regwrite_req(regwrite_req), .alu_result(ex_alu_result), .zero_flag(),
      .branch_taken(ex_branch_taken), .branch_target(ex_branch_target),
      .mem_read(ex_mem_read), .mem_write(ex_mem_write), .wb_sel(ex_wb_sel),
      .regwrite(ex_regwrite), .halt(ex_halt)
   );

   ex_mem_latch i_ex_mem_latch (
      .CLK(CLK), .nRST(nRST), .flush(latch_flush), .wen(ex_mem_wen),
      .mem_read(ex_mem_read), .mem_write(ex_mem_write), .regwrite(ex_regwrite),
      .wb_sel(ex_wb_sel), .halt(ex_halt), .branch_taken(ex_branch_taken),
      .alu_result(ex_alu_result), .store_data(rdat2), .npc(npc),
      .branch_target(ex_branch_target), .dest(dest),
      .mem_read_q(mem_rd), .mem_write_q(mem_wr), .regwrite_q(mem_regwrite),
      .wb_sel_q(mem_wb_sel), .halt_q(mem_halt), .branch_taken_q(branch_taken),
      .alu_result_q(mem_alu_result), .store_data_q(mem_store_data),
      .npc_q(mem_npc), .branch_target_q(branch_target), .dest_q(mem_dest)
   );

   data_memory i_data_memory (
      .CLK(CLK), .nRST(nRST), .mem_read(mem_rd), .mem_write(mem_wr),
      .addr(mem_alu_result), .wdata(mem_store_data), .rdata(dmem_rdata), .dhit(dhit)
   );

   mem_wb_latch i_mem_wb_latch (
      .CLK(CLK), .nRST(nRST), .mem_op(mem_op), .dhit(dhit), .regwrite(mem_regwrite),
      .wb_sel(mem_wb_sel), .alu_result(mem_alu_result), .rdata(dmem_rdata),
      .npc(mem_npc), .dest(mem_dest), .wb_valid(wb_valid), .wb_dest(wb_dest),
      .wb_data(wb_data)
   );

   hazard_unit i_hazard_unit (
      .CLK(CLK), .nRST(nRST), .mem_op(mem_op), .dhit(dhit),
      .branch_taken(branch_taken), .halt(mem_halt), .ex_mem_wen(ex_mem_wen),
      .flush(flush), .halted(halted)
   );

endmodule

`default_nettype wire

//--- dv/tb_mips_backend.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mips_backend;
   import cpu_types_pkg::*;

   localparam int TIMEOUT = 40;   // Cycles per wait loop

   logic     CLK = 1'b0;
   logic     nRST;
   logic     issue_valid;
   alu_op_t  op;
   word_t    rdat1, rdat2, imm, npc;
   regbits_t dest;
   logic     regwrite_req;
   logic     issue_ready;
   logic     wb_valid;
   regbits_t wb_dest;
   word_t    wb_data;
   logic     branch_taken;
   word_t    branch_target;
   logic     halted;

   // Reference model state
   word_t    lcg_state = 32'd75;
   word_t    mem_model [DMEM_DEPTH];
   word_t    exp_data [$];
   regbits_t exp_dest [$];
   int       exp_cyc [$];
   int       cycle = 0;
   int       br_cyc = -1;
   word_t    br_target = '0;
   logic     squash = 1'b0;   // Next accepted slot is a bubble
   string    test_name = "reset";

   always #4 CLK = ~CLK;

   always @(posedge CLK) cycle <= cycle + 1;

   mips_backend i_mips_backend (
      .CLK(CLK), .nRST(nRST), .issue_valid(issue_valid), .op(op), .rdat1(rdat1),
      .rdat2(rdat2), .imm(imm), .npc(npc), .dest(dest), .regwrite_req(regwrite_req),
      .issue_ready(issue_ready), .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data),
      .branch_taken(branch_taken), .branch_target(branch_target), .halted(halted)
   );

   function automatic word_t lcg();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   task automatic stop_with_error(input string why);
      $display("%s", why);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string what, input word_t expected, input word_t actual);
      stop_with_error($sformatf("mismatch %s %s: expected %h, actual %h",
                                test_name, what, expected, actual));
   endtask

   // Write-back value from the instruction rules
   function automatic word_t predict(alu_op_t o, word_t a, word_t b, word_t i, word_t n);
      word_t ea;
      ea = a + i;
      case (o)
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_AND:  return a & b;
         OP_OR:   return a | b;
         OP_XOR:  return a ^ b;
         OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         OP_SLL:  return a << b[4:0];
         OP_LUI:  return i << 16;
         OP_LW:   return mem_model[ea[DMEM_AW+1:2]];
         OP_JAL:  return n;   // Link
         default: return '0;
      endcase
   endfunction

   task automatic track_accept(input alu_op_t o, input word_t a, b, i, n,
                               input regbits_t d, input logic rw, input int acc);
      word_t ea;
      logic  taken;
      ea = a + i;
      if (squash) begin
         squash = 1'b0;
         return;
      end
      taken = (o == OP_BEQ && a == b) || (o == OP_BNE && a != b) || o == OP_JAL;
      if (taken) begin
         br_cyc    = acc;
         br_target = (o == OP_JAL) ? i << 2 : n + (i << 2);
         squash    = 1'b1;
      end
      if (rw && (o <= OP_LUI || o == OP_LW || o == OP_JAL)) begin
         exp_data.push_back(predict(o, a, b, i, n));
         exp_dest.push_back(d);
         exp_cyc.push_back((o == OP_LW) ? acc + DMEM_WAIT + 1 : acc + 1);
      end
      if (o == OP_SW) mem_model[ea[DMEM_AW+1:2]] = b;
   endtask

   // Offer one instruction and hold it until accepted
   task automatic issue(input alu_op_t o, input word_t a, b, i, n,
                        input regbits_t d, input logic rw, output int stalls);
      int waited;
      int acc;
      issue_valid  <= 1'b1;
      op           <= o;
      rdat1        <= a;
      rdat2        <= b;
      imm          <= i;
      npc          <= n;
      dest         <= d;
      regwrite_req <= rw;
      waited = 0;
      @(negedge CLK);
      while (!issue_ready) begin
         waited++;
         if (waited > TIMEOUT)
            stop_with_error($sformatf("issue_ready never rose for %s in %s",
                                      o.name(), test_name));
         @(negedge CLK);
      end
      acc = cycle + 1;
      @(posedge CLK);
      stalls = waited;
      track_accept(o, a, b, i, n, d, rw, acc);
   endtask

   task automatic drain();
      int waited;
      issue_valid <= 1'b0;
      squash = 1'b0;   // Idle cycle fills the branch shadow
      waited = 0;
      @(negedge CLK);
      while (exp_data.size() != 0) begin
         waited++;
         if (waited > TIMEOUT)
            stop_with_error($sformatf("expected write-back never appeared in %s", test_name));
         @(negedge CLK);
      end
      @(posedge CLK);
   endtask

   // Write-back and branch monitor
   always @(negedge CLK) begin
      if (nRST) begin
         if (wb_valid && exp_data.size() == 0) begin
            stop_with_error($sformatf("write-back to r%0d with none expected in %s",
                                      wb_dest, test_name));
         end else if (wb_valid) begin
            assert (wb_dest == exp_dest[0])
               else report_mismatch("wb_dest", word_t'(exp_dest[0]), word_t'(wb_dest));
            assert (wb_data == exp_data[0]) else report_mismatch("wb_data", exp_data[0], wb_data);
            assert (cycle == exp_cyc[0]) else report_mismatch("wb cycle", exp_cyc[0], cycle);
            void'(exp_data.pop_front());
            void'(exp_dest.pop_front());
            void'(exp_cyc.pop_front());
         end
         assert (branch_taken == (cycle == br_cyc))
            else report_mismatch("branch_taken", word_t'(cycle == br_cyc), word_t'(branch_taken));
         if (branch_taken)
            assert (branch_target == br_target)
               else report_mismatch("branch_target", br_target, branch_target);
      end
   end

   assert property (@(posedge CLK) disable iff (!nRST) halted |-> !issue_ready)
      else stop_with_error("issue_ready was high while halted");
   assert property (@(posedge CLK) disable iff (!nRST) branch_taken |-> issue_ready)
      else stop_with_error("EX/MEM stalled while holding a taken branch");

   initial begin
      int    stalls;
      word_t r, a, b, i, s;
      nRST         <= 1'b0;
      issue_valid  <= 1'b0;
      op           <= OP_ADD;
      rdat1        <= '0;
      rdat2        <= '0;
      imm          <= '0;
      npc          <= '0;
      dest         <= '0;
      regwrite_req <= 1'b0;
      repeat (2) @(posedge CLK);
      assert (!issue_ready)
         else report_mismatch("issue_ready in reset", 32'd0, word_t'(issue_ready));
      nRST <= 1'b1;
      @(negedge CLK);
      assert ({issue_ready, wb_valid, branch_taken, halted} == 4'b1000)
         else report_mismatch("reset outputs", 32'h8,
                              word_t'({issue_ready, wb_valid, branch_taken, halted}));
      @(posedge CLK);

      test_name = "alu";
      repeat (24) begin
         r = lcg();
         a = lcg();
         b = lcg();
         issue(alu_op_t'({1'b0, r[31:29]}), a, b, lcg(), lcg(), r[20:16], r[27], stalls);
      end
      drain();

      test_name = "memory";
      repeat (4) begin
         a = lcg();
         i = lcg();
         s = lcg();
         r = lcg();
         issue(OP_SW, a, s, i, 32'd0, 5'd0, 1'b0, stalls);
         issue(OP_LW, a, lcg(), i, 32'd0, r[4:0], 1'b1, stalls);
         assert (stalls == DMEM_WAIT) else report_mismatch("store stall", DMEM_WAIT, stalls);
         issue(OP_ADD, a, s, 32'd0, 32'd0, r[9:5], 1'b1, stalls);
         assert (stalls == DMEM_WAIT) else report_mismatch("load stall", DMEM_WAIT, stalls);
      end
      drain();

      test_name = "branch";
      a = lcg();
      i = lcg();
      s = lcg();
      b = lcg();
      issue(OP_SW, a, s, i, 32'd0, 5'd0, 1'b0, stalls);
      issue(OP_BEQ, b, b, lcg(), lcg(), 5'd0, 1'b1, stalls);
      issue(OP_SW, a, ~s, i, 32'd0, 5'd0, 1'b0, stalls);      // Squashed shadow store
      issue(OP_BNE, b, ~b, lcg(), lcg(), 5'd0, 1'b0, stalls);
      issue(OP_ADD, b, b, 32'd0, 32'd0, 5'd7, 1'b1, stalls);
      issue(OP_BEQ, b, ~b, lcg(), lcg(), 5'd0, 1'b0, stalls);  // Not taken
      issue(OP_ADD, b, a, 32'd0, 32'd0, 5'd8, 1'b1, stalls);
      issue(OP_BNE, a, a, lcg(), lcg(), 5'd0, 1'b0, stalls);
      issue(OP_OR, a, b, 32'd0, 32'd0, 5'd9, 1'b1, stalls);
      issue(OP_LW, a, 32'd0, i, 32'd0, 5'd10, 1'b1, stalls);   // Sees the first store only
      drain();

      test_name = "jal";
      issue(OP_JAL, lcg(), lcg(), lcg(), lcg(), 5'd31, 1'b1, stalls);
      issue(OP_ADD, lcg(), lcg(), 32'd0, 32'd0, 5'd1, 1'b1, stalls);
      drain();

      test_name = "halt";
      issue(OP_ADD, lcg(), lcg(), 32'd0, 32'd0, 5'd3, 1'b1, stalls);   // Retires ahead of HALT
      issue(OP_HALT, 32'd0, 32'd0, 32'd0, 32'd0, 5'd0, 1'b0, stalls);
      rdat1        <= lcg();
      op           <= OP_ADD;
      dest         <= 5'd2;
      regwrite_req <= 1'b1;
      @(negedge CLK);
      assert ({halted, issue_ready} == 2'b00)
         else report_mismatch("halt entry", 32'd0, word_t'({halted, issue_ready}));
      repeat (8) begin
         @(negedge CLK);
         assert ({halted, issue_ready} == 2'b10)
            else report_mismatch("halted state", 32'd2, word_t'({halted, issue_ready}));
      end
      assert (exp_data.size() == 0) else stop_with_error("write-back still outstanding at halt");

      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire

//--- mips_backend.f
logic/cpu_types_pkg.sv
logic/execute_stage.sv
logic/ex_mem_latch.sv
logic/data_memory.sv
logic/mem_wb_latch.sv
logic/hazard_unit.sv
logic/mips_backend.sv
dv/tb_mips_backend.sv

//--- run.sh
#!/bin/sh
# Build and run the mips_backend testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f mips_backend.f --top-module tb_mips_backend \
   -o sim_mips_backend || exit 1
./obj_dir/sim_mips_backend > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1
grep -q "PASS: all tests" sim.log || exit 1
exit 0
